/* hw/acqDataPkg.sv */
//////////////////////////////////////////////////////////////////////
// Sample format of the ADC input stream, shared by the data path.
// Imported by the decoder, the interface, the buffer and the top level.
//////////////////////////////////////////////////////////////////////

package acqDataPkg;

    //////////////////////////////////////////////////////////////////
    // Input word layout

    // Bits per sample slot in the input word
    localparam int axiSampleWidth = 16;

    // Significant converter bits, left-adjusted in each slot
    localparam int adcWidth = 14;

    // Unused low bits below the significant ones
    localparam int adcShift = axiSampleWidth - adcWidth;

    //////////////////////////////////////////////////////////////////
    // Sample type

    // Two's complement, as delivered by the converter
    typedef logic signed [adcWidth-1:0] adcSample;

endpackage

/* hw/acqCtrlPkg.sv */
//////////////////////////////////////////////////////////////////////
// Acquisition control types: sequencer states and trigger polarity.
//////////////////////////////////////////////////////////////////////

package acqCtrlPkg;

    // Sequencer states, also reported on the status port
    typedef enum logic [2:0] {
        Idle,
        Fill,
        Armed,
        Acquire,
        Done
    } acqState;

    // Which crossing of the trigger level counts
    typedef enum logic {
        Rising,
        Falling
    } trigMode;

endpackage

/* hw/sampleBusIf.sv */
//////////////////////////////////////////////////////////////////////
// Decoded sample words, compare flags and the write address, shared
// between the decoder, the sequencer, the trigger and the buffer.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface sampleBusIf import acqDataPkg::*; #(
    parameter int lanes       = 4,
    parameter int bufferDepth = 64
);
    localparam int addrWidth = $clog2(bufferDepth);

    logic                 wordValid;
    adcSample [lanes-1:0] samples;
    // Lanes past the trigger level, already polarity-corrected
    logic [lanes-1:0]     aboveLevel;
    logic [lanes-1:0]     belowLevel;
    logic                 writeEnable;
    logic [addrWidth-1:0] writeAddr;

    modport decoder (output wordValid, samples, aboveLevel, belowLevel);
    modport sequencer (input wordValid, output writeEnable, writeAddr);
    modport sink (
        input wordValid, samples, aboveLevel, belowLevel, writeEnable, writeAddr
    );

endinterface

/* hw/sampleDecode.sv */
//////////////////////////////////////////////////////////////////////
// Pulls the significant bits out of each input word and compares each
// lane with the trigger level. Output lands on the bus 3 cycles later.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sampleDecode import acqDataPkg::*; import acqCtrlPkg::*; #(
    parameter int lanes = 4
) (
    input  logic                            adcClk,
    input  logic                            arstN,
    input  logic                            axiValid,
    input  logic [lanes*axiSampleWidth-1:0] axiData,
    input  adcSample                        triggerLevel,
    input  trigMode                         mode,
    sampleBusIf.decoder                     bus
);
    logic [1:0]           validPipe;
    adcSample [lanes-1:0] preSample;
    adcSample [lanes-1:0] sample;

    // Valid travels alongside the two sample stages and the compare
    always_ff @(posedge adcClk or negedge arstN) begin
        if (!arstN) begin
            validPipe     <= '0;
            bus.wordValid <= 1'b0;
        end else begin
            validPipe     <= {validPipe[0], axiValid};
            bus.wordValid <= validPipe[1];
        end
    end

    always_ff @(posedge adcClk) begin
        for (int i = 0; i < lanes; i++) begin
            // Two stages purely for timing ahead of the comparators
            preSample[i]   <= axiData[i*axiSampleWidth+adcShift +: adcWidth];
            sample[i]      <= preSample[i];
            bus.samples[i] <= sample[i];

            // Polarity is folded in here so the trigger only ever looks at aboveLevel
            if (mode == Falling) begin
                bus.aboveLevel[i] <= sample[i] < triggerLevel;
                bus.belowLevel[i] <= sample[i] > triggerLevel;
            end else begin
                bus.aboveLevel[i] <= sample[i] > triggerLevel;
                bus.belowLevel[i] <= sample[i] < triggerLevel;
            end
        end
    end

endmodule

/* hw/triggerDetect.sv */
//////////////////////////////////////////////////////////////////////
// Level and event trigger. Level triggers need one fully idle word
// first; the trigger word address and lane are held after the pulse.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module triggerDetect #(
    parameter int  lanes       = 4,
    parameter int  bufferDepth = 64,
    parameter int  eventWidth  = 4,
    localparam int addrWidth   = $clog2(bufferDepth),
    localparam int laneWidth   = (lanes > 1) ? $clog2(lanes) : 1
) (
    input  logic                  adcClk,
    input  logic                  arstN,
    sampleBusIf.sink              bus,
    input  logic                  watch,
    input  logic [eventWidth-1:0] eventStrobes,
    input  logic [eventWidth-1:0] eventEnables,
    output logic                  triggered,
    output logic [addrWidth-1:0]  triggerAddr,
    output logic [laneWidth-1:0]  triggerLane
);
    logic                 watchD;
    logic                 beenIdle;
    logic                 caught;
    logic                 wordSeen;
    logic                 anyPast;
    logic                 eventHit;
    logic                 levelHit;
    logic                 fire;
    logic [laneWidth-1:0] firstLane;

    // Lowest lane with its flag set
    function automatic logic [laneWidth-1:0] lowestLane(input logic [lanes-1:0] flags);
        logic [laneWidth-1:0] lane;
        lane = '0;
        for (int i = lanes - 1; i >= 0; i--) begin
            if (flags[i]) begin
                lane = laneWidth'(i);
            end
        end
        return lane;
    endfunction

    assign wordSeen  = bus.wordValid && bus.writeEnable;
    assign anyPast   = |bus.aboveLevel;
    assign eventHit  = |(eventStrobes & eventEnables);
    assign levelHit  = wordSeen && anyPast && beenIdle && watchD;
    // Only the first hit per arming counts
    assign fire      = watch && !caught && (eventHit || levelHit);
    assign firstLane = lowestLane(bus.aboveLevel);

    always_ff @(posedge adcClk or negedge arstN) begin
        if (!arstN) begin
            watchD    <= 1'b0;
            beenIdle  <= 1'b0;
            caught    <= 1'b0;
            triggered <= 1'b0;
        end else begin
            watchD    <= watch;
            triggered <= fire;
            if (!watch) begin
                beenIdle <= 1'b0;
                caught   <= 1'b0;
            end else begin
                if (wordSeen && !anyPast) begin
                    beenIdle <= 1'b1;
                end
                if (fire) begin
                    caught <= 1'b1;
                end
            end
        end
    end

    // Events win over level crossings and always report lane 0
    always_ff @(posedge adcClk) begin
        if (fire) begin
            triggerAddr <= bus.writeAddr;
            triggerLane <= eventHit ? '0 : firstLane;
        end
    end

    // Sequencer keeps watch up through the pulse cycle
    trigInWatch: assert property (@(posedge adcClk) disable iff (!arstN)
        triggered |-> watch);

endmodule

/* hw/acqSequencer.sv */
//////////////////////////////////////////////////////////////////////
// Acquisition FSM: fills the pretrigger window, arms the trigger, then
// writes the post-trigger words into the circular buffer and stops.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module acqSequencer import acqCtrlPkg::*; #(
    parameter int  bufferDepth = 64,
    localparam int addrWidth   = $clog2(bufferDepth)
) (
    input  logic                 adcClk,
    input  logic                 arstN,
    input  logic                 start,
    input  logic [addrWidth-1:0] pretriggerWords,
    sampleBusIf.sequencer        bus,
    input  logic                 triggered,
    output logic                 watch,
    output logic                 acqActive,
    output logic                 acqDone,
    output acqState              state
);
    localparam int cntWidth = addrWidth + 1;

    logic                write;
    logic                lastWrite;
    logic [cntWidth-1:0] wordCount;
    logic [cntWidth-1:0] nextCount;
    logic [cntWidth-1:0] trigCount;

    assign write     = bus.wordValid && bus.writeEnable;
    assign nextCount = wordCount + cntWidth'(write);
    // Trigger word was written the cycle before the pulse, unless it was an event in a gap
    assign trigCount = wordCount + cntWidth'(lastWrite) + cntWidth'(write);
    assign acqActive = state inside {Fill, Armed, Acquire};
    assign acqDone   = state == Done;

    always_ff @(posedge adcClk or negedge arstN) begin
        if (!arstN) begin
            state           <= Idle;
            watch           <= 1'b0;
            bus.writeEnable <= 1'b0;
            bus.writeAddr   <= '0;
            wordCount       <= '0;
            lastWrite       <= 1'b0;
        end else begin
            lastWrite <= write;
            if (write) begin
                bus.writeAddr <= bus.writeAddr + 1'b1;
            end

            case (state)
                Idle: begin
                    if (start) begin
                        bus.writeAddr   <= '0;
                        bus.writeEnable <= 1'b1;
                        wordCount       <= '0;
                        state           <= Fill;
                    end
                end
                Fill: begin
                    wordCount <= nextCount;
                    if (nextCount >= cntWidth'(pretriggerWords)) begin
                        wordCount <= cntWidth'(pretriggerWords);
                        watch     <= 1'b1;
                        state     <= Armed;
                    end
                end
                // Pretrigger window slides here, so the count holds
                Armed: begin
                    if (triggered) begin
                        watch     <= 1'b0;
                        wordCount <= trigCount;
                        state     <= Acquire;
                        if (trigCount >= cntWidth'(bufferDepth)) begin
                            bus.writeEnable <= 1'b0;
                            state           <= Done;
                        end
                    end
                end
                Acquire: begin
                    wordCount <= nextCount;
                    if (nextCount >= cntWidth'(bufferDepth)) begin
                        bus.writeEnable <= 1'b0;
                        state           <= Done;
                    end
                end
                Done: begin
                    if (start) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Apart from the restart, the pointer steps by one on a valid write only
    ptrStep: assert property (@(posedge adcClk) disable iff (!arstN)
        ($past(state) != Idle && bus.writeAddr != $past(bus.writeAddr))
            |-> ($past(write) && bus.writeAddr == $past(bus.writeAddr) + 1'b1));

endmodule

/* hw/captureBuffer.sv */
//////////////////////////////////////////////////////////////////////
// Capture memory. Whole words are written from the bus; readback picks
// one lane of one word, with data valid two cycles after the address.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module captureBuffer import acqDataPkg::*; #(
    parameter int  lanes       = 4,
    parameter int  bufferDepth = 64,
    localparam int addrWidth   = $clog2(bufferDepth),
    localparam int laneWidth   = (lanes > 1) ? $clog2(lanes) : 1
) (
    input  logic                 adcClk,
    sampleBusIf.sink             bus,
    input  logic [addrWidth-1:0] readAddr,
    input  logic [laneWidth-1:0] readLane,
    output adcSample             readData
);
    adcSample [lanes-1:0] mem [bufferDepth];
    adcSample [lanes-1:0] readWord;
    logic [laneWidth-1:0] laneSel;

    //////////////////////////////////////////////////////////////////
    // Write port

    always_ff @(posedge adcClk) begin
        if (bus.wordValid && bus.writeEnable) begin
            mem[bus.writeAddr] <= bus.samples;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read port

    // Lane select is delayed to line up with the registered word
    always_ff @(posedge adcClk) begin
        readWord <= mem[readAddr];
        laneSel  <= readLane;
        readData <= readWord[laneSel];
    end

endmodule

/* hw/acqTop.sv */
//////////////////////////////////////////////////////////////////////
// ADC capture engine top level. Configuration and readback are plain
// level ports; start is a single-cycle pulse.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module acqTop import acqDataPkg::*; import acqCtrlPkg::*; #(
    parameter int  lanes       = 4,
    parameter int  bufferDepth = 64,
    parameter int  eventWidth  = 4,
    localparam int addrWidth   = $clog2(bufferDepth),
    localparam int laneWidth   = (lanes > 1) ? $clog2(lanes) : 1
) (
    input  logic                            adcClk,
    input  logic                            arstN,
    input  logic                            axiValid,
    input  logic [lanes*axiSampleWidth-1:0] axiData,
    input  logic [eventWidth-1:0]           eventStrobes,
    input  logic [eventWidth-1:0]           eventEnables,
    input  adcSample                        triggerLevel,
    input  trigMode                         mode,
    input  logic [addrWidth-1:0]            pretriggerWords,
    input  logic                            start,
    input  logic [addrWidth-1:0]            readAddr,
    input  logic [laneWidth-1:0]            readLane,
    output logic                            acqActive,
    output logic                            acqDone,
    output acqState                         acqStatus,
    output logic [addrWidth-1:0]            triggerAddr,
    output logic [laneWidth-1:0]            triggerLane,
    output adcSample                        readData
);
    logic watch;
    logic triggered;

    sampleBusIf #(.lanes(lanes), .bufferDepth(bufferDepth)) bus ();

    sampleDecode #(.lanes(lanes)) decode (
        .adcClk, .arstN, .axiValid, .axiData, .triggerLevel, .mode, .bus(bus.decoder)
    );

    triggerDetect #(.lanes(lanes), .bufferDepth(bufferDepth), .eventWidth(eventWidth)) trigger (
        .adcClk, .arstN, .bus(bus.sink), .watch, .eventStrobes, .eventEnables,
        .triggered, .triggerAddr, .triggerLane
    );

    acqSequencer #(.bufferDepth(bufferDepth)) sequencer (
        .adcClk, .arstN, .start, .pretriggerWords, .bus(bus.sequencer), .triggered,
        .watch, .acqActive, .acqDone, .state(acqStatus)
    );

    captureBuffer #(.lanes(lanes), .bufferDepth(bufferDepth)) buffer (
        .adcClk, .bus(bus.sink), .readAddr, .readLane, .readData
    );

endmodule

/* sim/acqTb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the capture engine: level, falling, idle-qualified and
// event triggers, then readback of a gapped capture against a model.
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module acqTb import acqDataPkg::*, acqCtrlPkg::*; ();

    localparam int lanes       = 4;
    localparam int bufferDepth = 64;
    localparam int eventWidth  = 4;
    localparam int addrWidth   = $clog2(bufferDepth);
    localparam int laneWidth   = $clog2(lanes);
    localparam int preWords    = 8;
    localparam int trigWord    = 20;
    localparam int cycleLimit  = 6 * (bufferDepth + 50) * 2;
    // Word kinds sent by the stimulus
    localparam int kIdle  = 0;
    localparam int kCross = 1;
    localparam int kPast  = 2;
    localparam int kRand  = 3;

    logic adcClk;
    logic arstN;
    logic axiValid;
    logic [lanes*axiSampleWidth-1:0] axiData;
    logic [eventWidth-1:0] eventStrobes;
    logic [eventWidth-1:0] eventEnables;
    adcSample triggerLevel;
    trigMode mode;
    logic [addrWidth-1:0] pretriggerWords;
    logic start;
    logic [addrWidth-1:0] readAddr;
    logic [laneWidth-1:0] readLane;
    logic acqActive;
    logic acqDone;
    acqState acqStatus;
    logic [addrWidth-1:0] triggerAddr;
    logic [laneWidth-1:0] triggerLane;
    adcSample readData;

    // Model of the buffer, indexed by the valid word count since start
    adcSample model [bufferDepth][lanes];
    logic [15:0] lfsr = 16'd79;
    int sentCount = 0;
    int expTotal = 0;
    int cycles = 0;
    logic started = 1'b0;
    logic capturing = 1'b0;
    logic [2:0] validDly = '0;
    int busWords = 0;
    logic eventRun = 1'b0;
    logic enabledSent = 1'b0;
    logic checkAddr = 1'b0;
    logic [addrWidth-1:0] expAddr = '0;
    logic [laneWidth-1:0] expLane = '0;
    logic rdReq = 1'b0;
    logic rdValid1 = 1'b0;
    logic rdValid2 = 1'b0;
    adcSample rdExp = '0;
    adcSample rdExp1 = '0;
    adcSample rdExp2 = '0;

    acqTop #(.lanes(lanes), .bufferDepth(bufferDepth), .eventWidth(eventWidth)) dut (
        .adcClk, .arstN, .axiValid, .axiData, .eventStrobes, .eventEnables, .triggerLevel,
        .mode, .pretriggerWords, .start, .readAddr, .readLane, .acqActive, .acqDone,
        .acqStatus, .triggerAddr, .triggerLane, .readData
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic nextBit();
        logic b;
        b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], b};
        return b;
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], nextBit()};
        end
        return v;
    endfunction

    // Level is zero, so past means positive when rising and negative when falling
    function automatic adcSample makeSample(input logic past);
        logic [15:0] r;
        r = randBits(12);
        if (past ^ (mode == Falling)) begin
            return {2'b01, r[11:0]};
        end else begin
            return {2'b11, r[11:0]};
        end
    endfunction

    task automatic nextCycle();
        @(posedge adcClk);
        #2;
    endtask

    task automatic sendWord(input int kind, input int lane);
        adcSample s;
        logic [15:0] r;
        while (randBits(2) == 16'd0) begin
            axiValid = 1'b0;
            nextCycle();
        end
        for (int l = 0; l < lanes; l++) begin
            r = randBits(16);
            s = r[13:0];
            if (kind == kIdle || (kind == kCross && l < lane)) begin
                s = makeSample(1'b0);
            end else if ((kind == kCross && l == lane) || (kind == kPast && l == 0)) begin
                s = makeSample(1'b1);
            end
            axiData[l*axiSampleWidth +: axiSampleWidth] = {s, r[15:14]};
            model[addrWidth'(sentCount)][l] = s;
        end
        axiValid = 1'b1;
        sentCount++;
        nextCycle();
    endtask

    task automatic startCapture();
        axiValid = 1'b0;
        repeat (4) nextCycle();
        sentCount = 0;
        started = 1'b1;
        capturing = 1'b1;
        start = 1'b1;
        nextCycle();
        start = 1'b0;
    endtask

    // Leaves Done for Idle so the next capture can start
    task automatic finishCapture();
        axiValid = 1'b0;
        while (!acqDone) begin
            nextCycle();
        end
        capturing = 1'b0;
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        nextCycle();
    endtask

    task automatic levelRun(input trigMode m, input int lane, input logic qualify);
        mode = m;
        eventRun = 1'b0;
        checkAddr = 1'b1;
        expAddr = addrWidth'(trigWord);
        expLane = laneWidth'(lane);
        expTotal = trigWord + bufferDepth - preWords;
        startCapture();
        for (int i = 0; i < trigWord; i++) begin
            sendWord((qualify && i < trigWord - 1) ? kPast : kIdle, 0);
        end
        sendWord(kCross, lane);
        while (sentCount < expTotal) begin
            sendWord(kRand, 0);
        end
        axiValid = 1'b0;
        while (!acqDone) begin
            nextCycle();
        end
    endtask

    task automatic eventTest();
        mode = Rising;
        eventRun = 1'b1;
        enabledSent = 1'b0;
        checkAddr = 1'b0;
        expLane = '0;
        expTotal = 0;
        startCapture();
        repeat (trigWord) sendWord(kIdle, 0);
        // Strobe on a lane that is not enabled
        eventStrobes = 4'b0010;
        sendWord(kIdle, 0);
        eventStrobes = '0;
        repeat (5) sendWord(kIdle, 0);
        enabledSent = 1'b1;
        eventStrobes = 4'b0001;
        sendWord(kIdle, 0);
        eventStrobes = '0;
        while (!acqDone) begin
            sendWord(kIdle, 0);
        end
    endtask

    task automatic readBack();
        for (int a = 0; a < bufferDepth; a++) begin
            for (int l = 0; l < lanes; l++) begin
                readAddr = addrWidth'(a);
                readLane = laneWidth'(l);
                rdExp = model[a][l];
                rdReq = 1'b1;
                nextCycle();
            end
        end
        rdReq = 1'b0;
        repeat (3) nextCycle();
    endtask

    // Expected read data follows the two-cycle read latency
    always @(posedge adcClk) begin
        rdValid1 <= rdReq;
        rdExp1   <= rdExp;
        rdValid2 <= rdValid1;
        rdExp2   <= rdExp1;
    end

    // Words reach the buffer three cycles after they are sent
    always @(posedge adcClk) begin
        validDly <= {validDly[1:0], axiValid};
        if (start) begin
            busWords <= 0;
        end else if (validDly[2]) begin
            busWords <= busWords + 1;
        end
    end

    always @(posedge adcClk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            failRun("Timeout: the captures did not complete within the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////
    // Checks

    idleAfterReset: assert property (@(posedge adcClk) disable iff (!arstN)
        !started |-> (!acqActive && !acqDone))
        else failRun($sformatf("[ERROR] acqActive/acqDone = %h/%h before start",
            $sampled(acqActive), $sampled(acqDone)));

    statusCheck: assert property (@(posedge adcClk) disable iff (!arstN)
        start |=> (acqStatus == (capturing ? Fill : Idle) && acqActive == capturing))
        else failRun($sformatf("[ERROR] acqStatus/acqActive = %h/%h expected %h/%h",
            $sampled(acqStatus), $sampled(acqActive), capturing ? Fill : Idle, capturing));

    // Trigger lane and address are held, so they are checked as the capture ends
    laneCheck: assert property (@(posedge adcClk) disable iff (!arstN)
        $rose(acqDone) |-> triggerLane == expLane)
        else failRun($sformatf("[ERROR] triggerLane = %h expected %h",
            $sampled(triggerLane), expLane));

    addrCheck: assert property (@(posedge adcClk) disable iff (!arstN)
        ($rose(acqDone) && checkAddr) |-> triggerAddr == expAddr)
        else failRun($sformatf("[ERROR] triggerAddr = %h expected %h",
            $sampled(triggerAddr), expAddr));

    eventCheck: assert property (@(posedge adcClk) disable iff (!arstN)
        ($past(acqStatus) == Armed && acqStatus != Armed && eventRun) |-> enabledSent)
        else failRun("A disabled event strobe triggered the capture");

    doneCheck: assert property (@(posedge adcClk) disable iff (!arstN)
        ($rose(acqDone) && expTotal != 0) |-> busWords == expTotal)
        else failRun($sformatf("[ERROR] words written at acqDone = %h expected %h",
            $sampled(busWords), expTotal));

    readCheck: assert property (@(posedge adcClk) rdValid2 |-> readData == rdExp2)
        else failRun($sformatf("[ERROR] readData = %h expected %h",
            $sampled(readData), rdExp2));

    initial begin
        adcClk = 1'b0;
        forever #10 adcClk = ~adcClk;
    end

    initial begin
        arstN = 1'b0;
        axiValid = 1'b0;
        axiData = '0;
        eventStrobes = '0;
        eventEnables = 4'b0001;
        triggerLevel = '0;
        mode = Rising;
        pretriggerWords = addrWidth'(preWords);
        start = 1'b0;
        readAddr = '0;
        readLane = '0;
        repeat (10) @(posedge adcClk);
        #2;
        arstN = 1'b1;
        repeat (3) nextCycle();

        levelRun(Rising, 1, 1'b0);
        readBack();
        finishCapture();
        levelRun(Falling, 3, 1'b0);
        finishCapture();
        levelRun(Rising, 2, 1'b1);
        finishCapture();
        eventTest();
        finishCapture();

        $display("Everything OK");
        $finish;
    end

endmodule

/* files.f */
hw/acqDataPkg.sv
hw/acqCtrlPkg.sv
hw/sampleBusIf.sv
hw/sampleDecode.sv
hw/triggerDetect.sv
hw/acqSequencer.sv
hw/captureBuffer.sv
hw/acqTop.sv
sim/acqTb.sv

/* Makefile */
# Verilator simulation of the ADC capture engine

VERILATOR ?= verilator
TOP       ?= acqTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench (fails on a failing run)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
